/* hw/conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// map side, at least 3
`define CONV_ROWS 8
// wide enough for rows * rows
`define CONV_ADDR_W 6

`define CONV_TAPS 9

// requantization
`define CONV_SHIFT 5
`define CONV_SAT_MAX 127

`endif

/* hw/conv_pkg.sv */
`include "conv_settings.svh"

package conv_pkg;

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	// code k selects byte k
	typedef logic [31:0] codebook_t;
	// tap k uses bits 2k+1..2k
	typedef logic [2*`CONV_TAPS-1:0] idx_vec_t;
	typedef logic signed [15:0] bias_t;

	// tap k = (dr + 1) * 3 + (dc + 1), eight bits per tap
	typedef logic [8*`CONV_TAPS-1:0] window_t;
	typedef logic [8*`CONV_TAPS-1:0] kernel_t;

	typedef logic signed [15:0] prod_t;
	typedef logic signed [19:0] acc_t;
	typedef logic [`CONV_ADDR_W-1:0] addr_t;

	typedef enum logic {
		fetch_idle,
		fetch_run
	} fetch_state_t;

endpackage

/* hw/window_fetch.sv */
`include "conv_settings.svh"

module window_fetch (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  conv_pkg::codebook_t codebook,
	input  conv_pkg::idx_vec_t  weight_idx,
	input  conv_pkg::bias_t     bias,
	output logic                in_cs,
	output conv_pkg::addr_t     in_addr,
	input  conv_pkg::pixel_t    in_rdata,
	output conv_pkg::window_t   window,
	output logic                window_valid,
	output conv_pkg::kernel_t   kernel,
	output conv_pkg::bias_t     bias_q
);

	localparam conv_pkg::addr_t last_pos = conv_pkg::addr_t'(`CONV_ROWS - 1);
	localparam logic [`CONV_ADDR_W:0] rows_ext = (`CONV_ADDR_W + 1)'(`CONV_ROWS);

	conv_pkg::fetch_state_t state;
	conv_pkg::addr_t row;
	conv_pkg::addr_t col;
	logic [1:0] ky;
	logic [1:0] kx;
	logic [3:0] tap;
	// neighbor position plus one, so -1 becomes 0
	logic [`CONV_ADDR_W:0] nr;
	logic [`CONV_ADDR_W:0] nc;
	logic pad;
	logic go;
	logic [3:0] d_tap;
	logic d_pad;
	logic d_valid;
	conv_pkg::pixel_t live;
	conv_pkg::window_t window_q;

	assign go = (state == conv_pkg::fetch_idle) && start;
	assign tap = {2'b00, ky} * 4'd3 + {2'b00, kx};

	assign nr = {1'b0, row} + (`CONV_ADDR_W + 1)'(ky);
	assign nc = {1'b0, col} + (`CONV_ADDR_W + 1)'(kx);
	assign pad = (nr == '0) || (nr > rows_ext) || (nc == '0) || (nc > rows_ext);

	assign in_cs = (state == conv_pkg::fetch_run) && !pad;
	assign in_addr = in_cs ? conv_pkg::addr_t'((nr - 1'b1) * rows_ext + (nc - 1'b1)) : '0;

	// tap, column, row counters
	always_ff @(posedge clk or negedge rst) begin
		if (~rst) begin
			state <= conv_pkg::fetch_idle;
			row <= '0;
			col <= '0;
			ky <= '0;
			kx <= '0;
		end else if (go) begin
			state <= conv_pkg::fetch_run;
		end else if (state == conv_pkg::fetch_run) begin
			if (kx == 2'd2) begin
				kx <= '0;
				if (ky == 2'd2) begin
					ky <= '0;
					if (col == last_pos) begin
						col <= '0;
						if (row == last_pos) begin
							row <= '0;
							state <= conv_pkg::fetch_idle;
						end else begin
							row <= row + 1'b1;
						end
					end else begin
						col <= col + 1'b1;
					end
				end else begin
					ky <= ky + 1'b1;
				end
			end else begin
				kx <= kx + 1'b1;
			end
		end
	end

	// follows the one cycle read latency
	always_ff @(posedge clk or negedge rst) begin
		if (~rst) begin
			d_valid <= 1'b0;
			d_tap <= '0;
			d_pad <= 1'b0;
		end else begin
			d_valid <= (state == conv_pkg::fetch_run);
			d_tap <= tap;
			d_pad <= pad;
		end
	end

	assign live = d_pad ? '0 : in_rdata;

	always_ff @(posedge clk) begin
		if (d_valid)
			window_q[d_tap*8 +: 8] <= live;
	end

	// last tap goes straight through so the window is whole one cycle earlier
	always_comb begin
		window = window_q;
		if (d_valid)
			window[d_tap*8 +: 8] = live;
	end

	assign window_valid = d_valid && (d_tap == 4'd8);

	always_ff @(posedge clk) begin
		if (go) begin
			bias_q <= bias;
			for (int k = 0; k < `CONV_TAPS; k++)
				kernel[k*8 +: 8] <= codebook[weight_idx[2*k +: 2]*8 +: 8];
		end
	end

endmodule

/* hw/mac_array.sv */
`include "conv_settings.svh"

module mac_array (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::window_t window,
	input  logic              window_valid,
	input  conv_pkg::kernel_t kernel,
	input  conv_pkg::bias_t   bias_q,
	output conv_pkg::acc_t    acc,
	output logic              acc_valid
);

	conv_pkg::prod_t prod [`CONV_TAPS];
	conv_pkg::bias_t bias_d;
	conv_pkg::acc_t sum;
	logic prod_valid;

	// stage one, nine products
	always_ff @(posedge clk) begin
		if (window_valid) begin
			bias_d <= bias_q;
			for (int k = 0; k < `CONV_TAPS; k++)
				prod[k] <= conv_pkg::prod_t'(conv_pkg::pixel_t'(window[k*8 +: 8]))
					* conv_pkg::prod_t'(conv_pkg::weight_t'(kernel[k*8 +: 8]));
		end
	end

	always_comb begin
		sum = conv_pkg::acc_t'(bias_d);
		for (int k = 0; k < `CONV_TAPS; k++)
			sum = sum + conv_pkg::acc_t'(prod[k]);
	end

	// stage two, adder tree result
	always_ff @(posedge clk) begin
		if (prod_valid)
			acc <= sum;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (~rst) begin
			prod_valid <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			prod_valid <= window_valid;
			acc_valid <= prod_valid;
		end
	end

endmodule

/* hw/requant_write.sv */
`include "conv_settings.svh"

module requant_write (
	input  logic             clk,
	input  logic             rst,
	input  conv_pkg::acc_t   acc,
	input  logic             acc_valid,
	output logic             out_we,
	output conv_pkg::addr_t  out_addr,
	output conv_pkg::pixel_t out_wdata,
	output logic             finish
);

	localparam conv_pkg::addr_t last_addr =
		conv_pkg::addr_t'(`CONV_ROWS * `CONV_ROWS - 1);

	conv_pkg::acc_t shifted;
	conv_pkg::pixel_t q;

	// relu, shift, saturate
	always_comb begin
		shifted = acc >>> `CONV_SHIFT;
		if (acc < conv_pkg::acc_t'(0))
			q = '0;
		else if (shifted > conv_pkg::acc_t'(`CONV_SAT_MAX))
			q = conv_pkg::pixel_t'(`CONV_SAT_MAX);
		else
			q = conv_pkg::pixel_t'(shifted);
	end

	always_ff @(posedge clk) begin
		if (acc_valid)
			out_wdata <= q;
	end

	// address moves on after each write, finish follows the last one
	always_ff @(posedge clk or negedge rst) begin
		if (~rst) begin
			out_we <= 1'b0;
			out_addr <= '0;
			finish <= 1'b0;
		end else begin
			out_we <= acc_valid;
			finish <= out_we && (out_addr == last_addr);
			if (out_we)
				out_addr <= (out_addr == last_addr) ? '0 : out_addr + 1'b1;
		end
	end

endmodule

/* hw/conv3x3_top.sv */
module conv3x3_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  conv_pkg::codebook_t codebook,
	input  conv_pkg::idx_vec_t  weight_idx,
	input  conv_pkg::bias_t     bias,
	output logic                in_cs,
	output conv_pkg::addr_t     in_addr,
	input  conv_pkg::pixel_t    in_rdata,
	output logic                out_we,
	output conv_pkg::addr_t     out_addr,
	output conv_pkg::pixel_t    out_wdata,
	output logic                finish
);

	conv_pkg::window_t window;
	logic window_valid;
	conv_pkg::kernel_t kernel;
	conv_pkg::bias_t bias_q;
	conv_pkg::acc_t acc;
	logic acc_valid;

	window_fetch fetch0 (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.codebook     (codebook),
		.weight_idx   (weight_idx),
		.bias         (bias),
		.in_cs        (in_cs),
		.in_addr      (in_addr),
		.in_rdata     (in_rdata),
		.window       (window),
		.window_valid (window_valid),
		.kernel       (kernel),
		.bias_q       (bias_q)
	);

	mac_array mac0 (
		.clk          (clk),
		.rst          (rst),
		.window       (window),
		.window_valid (window_valid),
		.kernel       (kernel),
		.bias_q       (bias_q),
		.acc          (acc),
		.acc_valid    (acc_valid)
	);

	requant_write wr0 (
		.clk       (clk),
		.rst       (rst),
		.acc       (acc),
		.acc_valid (acc_valid),
		.out_we    (out_we),
		.out_addr  (out_addr),
		.out_wdata (out_wdata),
		.finish    (finish)
	);

endmodule

/* sim/conv3x3_tb.sv */
`include "conv_settings.svh"

module conv3x3_tb;

	localparam int n = `CONV_ROWS;
	localparam int nn = `CONV_ROWS * `CONV_ROWS;

	logic clk;
	logic rst;
	logic start;
	conv_pkg::codebook_t codebook;
	conv_pkg::idx_vec_t weight_idx;
	conv_pkg::bias_t bias;
	logic in_cs;
	conv_pkg::addr_t in_addr;
	conv_pkg::pixel_t in_rdata;
	logic out_we;
	conv_pkg::addr_t out_addr;
	conv_pkg::pixel_t out_wdata;
	logic finish;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	bit hung;
	int cyc;
	logic rd_en;
	int rd_addr;
	int in_mem [nn];
	int exp_out [nn];
	int out_mem [nn];
	int write_count;
	int finish_count;
	int start_edge;
	int last_we;

	conv3x3_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.codebook   (codebook),
		.weight_idx (weight_idx),
		.bias       (bias),
		.in_cs      (in_cs),
		.in_addr    (in_addr),
		.in_rdata   (in_rdata),
		.out_we     (out_we),
		.out_addr   (out_addr),
		.out_wdata  (out_wdata),
		.finish     (finish)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
	endtask

	// input memory, data one cycle after the read
	always @(negedge clk) begin
		rd_en = in_cs;
		rd_addr = int'(in_addr);
	end

	always @(posedge clk) begin
		#10;
		if (rd_en && rd_addr < nn)
			in_rdata = conv_pkg::pixel_t'(in_mem[rd_addr]);
	end

	// one tap per cycle from the start edge, padded taps do not read
	always @(negedge clk) begin
		int step;
		int r;
		int c;
		bit cs_exp;
		int addr_exp;
		if (rst) begin
			step = cyc - start_edge;
			cs_exp = 1'b0;
			addr_exp = 0;
			if (step >= 0 && step < nn * 9) begin
				r = step / 9 / n + (step % 9) / 3 - 1;
				c = step / 9 % n + step % 3 - 1;
				cs_exp = r >= 0 && r < n && c >= 0 && c < n;
				addr_exp = r * n + c;
			end
			assert (in_cs == cs_exp && (!cs_exp || int'(in_addr) == addr_exp))
				else report_mismatch($sformatf("read cs %0b addr %0d, expected cs %0b addr %0d",
					in_cs, in_addr, cs_exp, addr_exp));
		end
	end

	assert property (@(posedge clk) disable iff (!rst) out_we |=> !out_we)
		else report_mismatch("writes in two consecutive cycles");

	// output memory and write timing
	always @(negedge clk) begin
		if (rst && out_we) begin
			assert (int'(out_addr) == write_count % nn)
				else report_mismatch($sformatf("write %0d at address %0d",
					write_count, out_addr));
			assert (int'(out_wdata) == exp_out[out_addr])
				else report_mismatch($sformatf("pixel %0d is %0d, expected %0d",
					out_addr, out_wdata, exp_out[out_addr]));
			if (write_count == 0) begin
				assert (cyc + 1 - start_edge == 13)
					else report_mismatch($sformatf("first write %0d cycles after start",
						cyc + 1 - start_edge));
			end else begin
				assert (cyc - last_we == 9)
					else report_mismatch($sformatf("writes %0d cycles apart", cyc - last_we));
			end
			out_mem[out_addr] = int'(out_wdata);
			last_we = cyc;
			write_count++;
		end
		if (rst && finish) begin
			assert (write_count == nn && cyc == last_we + 1)
				else report_mismatch($sformatf("finish after %0d writes", write_count));
			assert (finish_count == 0)
				else report_mismatch("second finish pulse in one frame");
			finish_count++;
		end
	end

	// expected frame from the map, decoded weights and bias
	task automatic build_expected();
		int acc;
		int code;
		int w [`CONV_TAPS];
		for (int k = 0; k < `CONV_TAPS; k++) begin
			code = int'(weight_idx[2*k +: 2]);
			w[k] = int'($signed(codebook[8*code +: 8]));
		end
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				acc = int'(bias);
				for (int dr = -1; dr <= 1; dr++)
					for (int dc = -1; dc <= 1; dc++)
						if (r + dr >= 0 && r + dr < n && c + dc >= 0 && c + dc < n)
							acc += in_mem[(r + dr) * n + c + dc] * w[(dr + 1) * 3 + dc + 1];
				if (acc < 0)
					exp_out[r * n + c] = 0;
				else if ((acc >>> `CONV_SHIFT) > `CONV_SAT_MAX)
					exp_out[r * n + c] = `CONV_SAT_MAX;
				else
					exp_out[r * n + c] = acc >>> `CONV_SHIFT;
			end
		end
	endtask

	task automatic fill_map(input bit positive);
		for (int a = 0; a < nn; a++)
			in_mem[a] = positive ? 64 + int'($unsigned($random(seed)) % 64)
				: $random(seed) % 128;
	endtask

	task automatic run_frame(input bit mid_start);
		int waited;
		if (hung)
			return;
		build_expected();
		write_count = 0;
		finish_count = 0;
		for (int a = 0; a < nn; a++)
			out_mem[a] = -1;
		@(posedge clk);
		#10;
		start = 1'b1;
		start_edge = cyc + 1;
		@(posedge clk);
		#10;
		start = 1'b0;
		waited = 0;
		while (finish_count == 0 && waited < nn * 9 + 100) begin
			@(posedge clk);
			waited++;
			// busy, this start must be ignored
			if (mid_start && waited == 200) begin
				#10;
				start = 1'b1;
				@(posedge clk);
				#10;
				start = 1'b0;
				waited++;
			end
		end
		if (finish_count == 0) begin
			$display("timeout: no finish pulse within %0d cycles", waited);
			hung = 1'b1;
		end else begin
			for (int i = 0; i < 40; i++)
				@(posedge clk);
			#10;
			assert (write_count == nn)
				else report_mismatch($sformatf("%0d writes in the frame", write_count));
			assert (finish_count == 1)
				else report_mismatch($sformatf("%0d finish pulses", finish_count));
		end
	endtask

	task automatic check_all_equal(input int value);
		for (int a = 0; a < nn; a++)
			assert (out_mem[a] == value)
				else report_mismatch($sformatf("pixel %0d is %0d, expected %0d",
					a, out_mem[a], value));
	endtask

	task automatic close_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before && !hung) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end
	endtask

	initial begin
		int e0;
		logic [1:0] code;
		seed = 32'h6087_8960;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		hung = 1'b0;
		cyc = 0;
		start_edge = -nn * 9;
		rd_en = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		codebook = '0;
		weight_idx = '0;
		bias = '0;
		in_rdata = '0;

		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			assert (!in_cs && !out_we && !finish)
				else report_mismatch("outputs active during reset");
		end
		@(posedge clk);
		#10;
		rst = 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			assert (!in_cs && !out_we && !finish)
				else report_mismatch("outputs active after reset");
		end
		@(posedge clk);
		#10;
		close_test("reset state", e0);

		e0 = errors;
		fill_map(1'b0);
		codebook = $random(seed);
		weight_idx = conv_pkg::idx_vec_t'($random(seed));
		bias = conv_pkg::bias_t'($random(seed) % 2048);
		run_frame(1'b0);
		close_test("random frame", e0);

		e0 = errors;
		fill_map(1'b1);
		codebook = 32'h7f7f_7f7f;
		bias = 16'sd100;
		run_frame(1'b0);
		check_all_equal(`CONV_SAT_MAX);
		codebook = 32'h8181_8181;
		bias = '0;
		run_frame(1'b0);
		check_all_equal(0);
		close_test("clamping", e0);

		e0 = errors;
		fill_map(1'b0);
		codebook = 32'h19f3_0be7;
		bias = -16'sd40;
		for (int k = 0; k < 4; k++) begin
			code = k[1:0];
			weight_idx = {9{code}};
			run_frame(1'b0);
			for (int t = 0; t < `CONV_TAPS; t++)
				assert (dut0.fetch0.kernel[8*t +: 8] == codebook[8*k +: 8])
					else report_mismatch($sformatf("tap %0d weight with code %0d", t, k));
		end
		close_test("codebook select", e0);

		e0 = errors;
		fill_map(1'b0);
		codebook = $random(seed);
		weight_idx = conv_pkg::idx_vec_t'($random(seed));
		bias = conv_pkg::bias_t'($random(seed) % 4096);
		run_frame(1'b0);
		close_test("addressing", e0);

		e0 = errors;
		fill_map(1'b0);
		run_frame(1'b1);
		close_test("finish and busy", e0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !hung)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+hw
hw/conv_pkg.sv
hw/window_fetch.sv
hw/mac_array.sv
hw/requant_write.sv
hw/conv3x3_top.sv
sim/conv3x3_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the conv3x3 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module conv3x3_tb --Mdir obj_dir

status=0
./obj_dir/Vconv3x3_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

exit "$status"
